// File: project.f
+incdir+tb
logic/dwc_pkg.sv
logic/dwc_write_packer.sv
logic/dwc_read_unpacker.sv
logic/dwc_upsizer.sv
tb/tb_dwc_upsizer.sv

// File: run_sim.sh
#!/bin/sh
# Build the upsizer testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing --assert -Wall -Wno-fatal -f project.f \
  --top-module tb_dwc_upsizer -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
if grep -q "Done: errors found" sim.log; then
  exit 1
fi
grep -q "Done: no errors" sim.log || exit 1
exit 0

// File: tb/dwc_stim.txt
# kind(0 write, 1 read) addr len size cache bresp backpressure, all hex
# burst is always INCR; cache bit 1 selects upsizing when len > 0
0 00001000 3 2 2 0 0
0 00001004 4 2 2 1 0
0 00001002 5 1 f 0 0
0 00001003 6 0 2 2 0
0 00001010 3 2 0 0 0
0 00001006 0 1 2 3 0
0 00001001 2 2 0 1 0
0 00001020 0 2 2 0 0
0 00001100 f 2 2 0 1
0 00001204 7 1 2 2 1
0 00001301 9 0 3 1 1
0 00001400 5 2 0 3 1
1 00002000 3 2 2 0 0
1 00002004 4 2 2 0 0
1 00002002 5 1 f 0 0
1 00002003 6 0 2 0 0
1 00002010 3 2 0 0 0
1 00002006 0 1 2 0 0
1 00002001 2 2 0 0 0
1 00002100 f 2 2 0 1
1 00002204 7 1 2 0 1
1 00002301 9 0 3 0 1
1 00002400 5 2 0 0 1
0 00003008 b 2 2 2 1
1 00003008 b 2 2 0 1
0 0000300c 1 2 2 1 0
1 0000300c 1 2 2 0 0

// File: tb/dwc_checks.svh
// Compare tasks and expected-value helpers for the upsizer testbench.
// Included inside the testbench module, uses its error counter.

// Memory and write-data rule: low address byte XOR 0x5A
function automatic logic [7:0] rule_byte(input logic [ADDR_W-1:0] a);
  return a[7:0] ^ 8'h5A;
endfunction

// Address of narrow beat k in an INCR burst
function automatic logic [ADDR_W-1:0] narrow_addr(input dwc_ax_t ax, input int k);
  if (k == 0) begin
    return ax.addr;
  end
  return ((ax.addr >> ax.size) << ax.size) + (ADDR_W'(k) << ax.size);
endfunction

// Narrow strobes: bytes from the address up to the end of its size chunk
function automatic logic [3:0] narrow_strb(input logic [ADDR_W-1:0] a, input logic [2:0] size);
  logic [ADDR_W-1:0] hi;
  logic [ADDR_W-1:0] b;
  logic [3:0]        s;
  hi = ((a >> size) << size) + (ADDR_W'(1) << size) - 1;
  s  = '0;
  for (int n = 0; n < 4; n++) begin
    b    = {a[ADDR_W-1:2], 2'(n)};
    s[n] = (b >= a) && (b <= hi);
  end
  return s;
endfunction

function automatic logic [31:0] narrow_word(input logic [ADDR_W-1:0] a);
  logic [31:0] w;
  for (int n = 0; n < 4; n++) begin
    w[8*n +: 8] = rule_byte({a[ADDR_W-1:2], 2'(n)});
  end
  return w;
endfunction

function automatic logic [63:0] wide_block(input logic [ADDR_W-1:0] a);
  logic [63:0] w;
  for (int i = 0; i < 8; i++) begin
    w[8*i +: 8] = rule_byte({a[ADDR_W-1:3], 3'(i)});
  end
  return w;
endfunction

function automatic logic [63:0] byte_mask(input logic [7:0] strb);
  logic [63:0] m;
  for (int i = 0; i < 8; i++) begin
    m[8*i +: 8] = {8{strb[i]}};
  end
  return m;
endfunction

task automatic check_ax(input string name, input dwc_ax_t got, input dwc_ax_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_mst_w(input string name, input dwc_mst_w_t got, input dwc_mst_w_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_slv_r(input string name, input dwc_slv_r_t got, input dwc_slv_r_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_b(input string name, input dwc_b_t got, input dwc_b_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

// File: tb/tb_dwc_upsizer.sv
// Testbench for the AXI upsizer. Reads one burst per line from the stimulus
// file, models the narrow master and the wide slave, checks every transfer.
`timescale 1ns/100ps

module tb_dwc_upsizer;
  import dwc_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk_i;
  logic       rst_ni;
  dwc_ax_t    slv_aw_i, slv_ar_i, mst_aw_o, mst_ar_o;
  logic       slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  dwc_slv_w_t slv_w_i;
  logic       slv_w_valid_i, slv_w_ready_o;
  dwc_b_t     slv_b_o, mst_b_i;
  logic       slv_b_valid_o, slv_b_ready_i, mst_b_valid_i, mst_b_ready_o;
  dwc_slv_r_t slv_r_o;
  logic       slv_r_valid_o, slv_r_ready_i;
  logic       mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  dwc_mst_w_t mst_w_o;
  logic       mst_w_valid_o, mst_w_ready_i;
  dwc_mst_r_t mst_r_i;
  logic       mst_r_valid_i, mst_r_ready_o;

  int     err_cnt;
  int     test_cnt;
  int     fail_cnt;
  logic   timed_out;
  integer seed;

  `include "dwc_checks.svh"

  dwc_upsizer dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic pick_ready(input logic bp);
    return bp ? (($random(seed) & 3) != 0) : 1'b1;
  endfunction

  // One cycle of a wait loop, gives up after the timeout
  task automatic next_cycle(inout int cycles, input string what);
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: %s did not complete within %0d cycles", what, TIMEOUT_CYCLES);
      err_cnt++;
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_write(input dwc_ax_t ax, input dwc_b_t bresp, input logic bp);
    dwc_mst_w_t        exp_w[$];
    dwc_mst_w_t        beat;
    dwc_mst_w_t        got;
    dwc_ax_t           exp_aw;
    logic [ADDR_W-1:0] a;
    logic [3:0]        s;
    logic              upsize;
    logic              aw_sent;
    logic              aw_seen;
    logic              b_done;
    int                w_idx;
    int                mw_idx;
    int                cycles;
    int                lane;
    upsize = (ax.burst == BURST_INCR) && ax.cache[CACHE_MODIFIABLE_BIT] && (ax.len != 0);
    beat   = '0;
    // Group narrow beats into wide beats by 8-byte block
    for (int k = 0; k <= int'(ax.len); k++) begin
      a = narrow_addr(ax, k);
      s = narrow_strb(a, ax.size);
      if (k != 0 && (!upsize || (a >> 3) != (narrow_addr(ax, k - 1) >> 3))) begin
        exp_w.push_back(beat);
        beat = '0;
      end
      for (int n = 0; n < 4; n++) begin
        if (s[n]) begin
          lane = 4 * a[2] + n;
          beat.strb[lane]        = 1'b1;
          beat.data[8*lane +: 8] = rule_byte({a[ADDR_W-1:2], 2'(n)});
        end
      end
    end
    beat.last = 1'b1;
    exp_w.push_back(beat);
    exp_aw = ax;
    if (upsize) begin
      exp_aw.len  = 8'(exp_w.size() - 1);
      exp_aw.size = 3'd3;
    end
    aw_sent = 0;
    aw_seen = 0;
    b_done  = 0;
    w_idx   = 0;
    mw_idx  = 0;
    cycles  = 0;
    while (!b_done && !timed_out) begin
      a                = narrow_addr(ax, w_idx);
      slv_aw_i         = ax;
      slv_aw_valid_i   = !aw_sent;
      slv_w_valid_i    = (w_idx <= int'(ax.len));
      slv_w_i.data     = narrow_word(a);
      slv_w_i.strb     = narrow_strb(a, ax.size);
      slv_w_i.last     = (w_idx == int'(ax.len));
      mst_aw_ready_i   = pick_ready(bp);
      mst_w_ready_i    = pick_ready(bp);
      mst_b_i          = bresp;
      mst_b_valid_i    = (mw_idx == exp_w.size());
      slv_b_ready_i    = pick_ready(bp);
      @(negedge clk_i);
      if (slv_aw_valid_i && slv_aw_ready_o) aw_sent = 1;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        check_ax("mst_aw", mst_aw_o, exp_aw);
        aw_seen = 1;
      end
      if (slv_w_valid_i && slv_w_ready_o) w_idx++;
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (mw_idx >= exp_w.size()) begin
          $display("Wide write beat %0d arrived but none was expected", mw_idx);
          err_cnt++;
        end else begin
          got      = mst_w_o;
          got.data = got.data & byte_mask(exp_w[mw_idx].strb);
          check_mst_w("mst_w", got, exp_w[mw_idx]);
        end
        mw_idx++;
      end
      if ((mst_b_valid_i && mst_b_ready_o) != (slv_b_valid_o && slv_b_ready_i)) begin
        $display("Write response handshake differs between the wide and the narrow side");
        err_cnt++;
      end
      if (slv_b_valid_o && slv_b_ready_i) begin
        check_b("slv_b", slv_b_o, bresp);
        b_done = 1;
      end
      next_cycle(cycles, "write burst");
    end
    if (!timed_out && !aw_seen) begin
      $display("Write burst ended without a wide AW transfer");
      err_cnt++;
    end
    slv_aw_valid_i = 1'b0;
    slv_w_valid_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
  endtask

  task automatic run_read(input dwc_ax_t ax, input logic bp);
    dwc_ax_t           exp_ar;
    dwc_slv_r_t        exp_r;
    dwc_slv_r_t        got;
    logic [ADDR_W-1:0] a;
    logic [63:0]       mask;
    logic [31:0]       m;
    logic              upsize;
    logic              ar_sent;
    logic              ar_seen;
    int                nblk;
    int                r_idx;
    int                mr_idx;
    int                cycles;
    upsize = (ax.burst == BURST_INCR) && ax.cache[CACHE_MODIFIABLE_BIT] && (ax.len != 0);
    nblk   = 1;
    for (int k = 1; k <= int'(ax.len); k++) begin
      if ((narrow_addr(ax, k) >> 3) != (narrow_addr(ax, k - 1) >> 3)) nblk++;
    end
    exp_ar = ax;
    if (upsize) begin
      exp_ar.len  = 8'(nblk - 1);
      exp_ar.size = 3'd3;
    end
    ar_sent = 0;
    ar_seen = 0;
    r_idx   = 0;
    mr_idx  = 0;
    cycles  = 0;
    while (r_idx <= int'(ax.len) && !timed_out) begin
      a = upsize ? ((ax.addr >> 3) << 3) + ADDR_W'(8 * mr_idx) : narrow_addr(ax, mr_idx);
      slv_ar_i       = ax;
      slv_ar_valid_i = !ar_sent;
      mst_r_valid_i  = ar_seen && (mr_idx <= int'(exp_ar.len));
      mst_r_i.data   = wide_block(a);
      mst_r_i.resp   = 2'b00;
      mst_r_i.last   = (mr_idx == int'(exp_ar.len));
      mst_ar_ready_i = pick_ready(bp);
      slv_r_ready_i  = pick_ready(bp);
      @(negedge clk_i);
      if (slv_ar_valid_i && slv_ar_ready_o) ar_sent = 1;
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        check_ax("mst_ar", mst_ar_o, exp_ar);
        ar_seen = 1;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        a          = narrow_addr(ax, r_idx);
        mask       = byte_mask({4'b0, narrow_strb(a, ax.size)});
        m          = mask[31:0];
        exp_r.data = narrow_word(a) & m;
        exp_r.resp = 2'b00;
        exp_r.last = (r_idx == int'(ax.len));
        got        = slv_r_o;
        got.data   = got.data & m;
        check_slv_r("slv_r", got, exp_r);
        r_idx++;
      end
      if (mst_r_valid_i && mst_r_ready_o) mr_idx++;
      next_cycle(cycles, "read burst");
    end
    if (!timed_out && mr_idx != int'(exp_ar.len) + 1) begin
      $display("Read burst used %0d wide beats instead of %0d", mr_idx, exp_ar.len + 1);
      err_cnt++;
    end
    slv_ar_valid_i = 1'b0;
    mst_r_valid_i  = 1'b0;
  endtask

  initial begin
    integer      fd;
    int          fields;
    int          errs_before;
    string       line;
    logic [31:0] kind, addr, len, size, cache, bresp, bp;
    dwc_ax_t     ax;
    dwc_b_t      b;
    seed = 96;
    err_cnt = 0;
    test_cnt = 0;
    fail_cnt = 0;
    timed_out = 1'b0;
    rst_ni = 1'b0;
    slv_aw_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i = '0;
    slv_w_valid_i = 1'b0;
    slv_b_ready_i = 1'b1;
    slv_ar_i = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i = 1'b0;
    mst_b_i = '0;
    mst_b_valid_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i = '0;
    mst_r_valid_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen("tb/dwc_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/dwc_stim.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h %h %h %h", kind, addr, len, size, cache, bresp, bp);
        if (fields == 7) begin
          ax.addr  = addr;
          ax.len   = len[7:0];
          ax.size  = size[2:0];
          ax.burst = BURST_INCR;
          ax.cache = cache[3:0];
          b.resp   = bresp[1:0];
          errs_before = err_cnt;
          if (kind == 0) run_write(ax, b, bp[0]);
          else run_read(ax, bp[0]);
          test_cnt++;
          if (err_cnt != errs_before) fail_cnt++;
          $display("Test %0d %s addr %h len %0d size %0d cache %h bp %0d: %s", test_cnt,
                   (kind == 0) ? "write" : "read", addr, len, size, cache, bp,
                   (err_cnt != errs_before) ? "FAILED" : "ok");
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && test_cnt > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: logic/dwc_upsizer.sv
// AXI data-width upsizer from a 32-bit master to a 64-bit slave.
// One write and one read burst in flight; B passes straight through.
`timescale 1ns/100ps

module dwc_upsizer
  import dwc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // Narrow side, driven by the outside master
  input  dwc_ax_t    slv_aw_i,
  input  logic       slv_aw_valid_i,
  output logic       slv_aw_ready_o,
  input  dwc_slv_w_t slv_w_i,
  input  logic       slv_w_valid_i,
  output logic       slv_w_ready_o,
  output dwc_b_t     slv_b_o,
  output logic       slv_b_valid_o,
  input  logic       slv_b_ready_i,
  input  dwc_ax_t    slv_ar_i,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  output dwc_slv_r_t slv_r_o,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  // Wide side, facing the outside slave
  output dwc_ax_t    mst_aw_o,
  output logic       mst_aw_valid_o,
  input  logic       mst_aw_ready_i,
  output dwc_mst_w_t mst_w_o,
  output logic       mst_w_valid_o,
  input  logic       mst_w_ready_i,
  input  dwc_b_t     mst_b_i,
  input  logic       mst_b_valid_i,
  output logic       mst_b_ready_o,
  output dwc_ax_t    mst_ar_o,
  output logic       mst_ar_valid_o,
  input  logic       mst_ar_ready_i,
  input  dwc_mst_r_t mst_r_i,
  input  logic       mst_r_valid_i,
  output logic       mst_r_ready_o
);

  dwc_write_packer u_write (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_aw_i      (slv_aw_i),
    .slv_aw_valid_i(slv_aw_valid_i),
    .slv_aw_ready_o(slv_aw_ready_o),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_aw_o      (mst_aw_o),
    .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_ready_i(mst_aw_ready_i),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  dwc_read_unpacker u_read (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_ar_i      (slv_ar_i),
    .slv_ar_valid_i(slv_ar_valid_i),
    .slv_ar_ready_o(slv_ar_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .mst_ar_o      (mst_ar_o),
    .mst_ar_valid_o(mst_ar_valid_o),
    .mst_ar_ready_i(mst_ar_ready_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o)
  );

  // Write response needs no conversion
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: logic/dwc_read_unpacker.sv
// Read path of the upsizer. Registers one AR request, rewrites it for the
// wide bus and hands each wide R beat out as one or more narrow beats.
`timescale 1ns/100ps

module dwc_read_unpacker
  import dwc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  dwc_ax_t    slv_ar_i,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  output dwc_slv_r_t slv_r_o,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  output dwc_ax_t    mst_ar_o,
  output logic       mst_ar_valid_o,
  input  logic       mst_ar_ready_i,
  input  dwc_mst_r_t mst_r_i,
  input  logic       mst_r_valid_i,
  output logic       mst_r_ready_o
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_PASSTHROUGH,
    R_UPSIZE
  } r_state_e;

  r_state_e          state_q;
  logic              ar_valid_q;
  // Narrow beats still to be returned
  logic [8:0]        cnt_q;

  dwc_ax_t           ar_q;
  logic [ADDR_W-1:0] addr_q;
  logic [2:0]        size_q;
  logic [1:0]        burst_q;

  logic              ar_hs;
  logic              r_hs;
  logic              active;
  logic [ADDR_W-1:0] addr_next;
  logic              word_used;
  dwc_ax_t           ar_rewritten;

  assign slv_ar_ready_o = (state_q == R_IDLE);
  assign ar_hs          = slv_ar_valid_i && slv_ar_ready_o;
  assign active         = (state_q != R_IDLE) && !ar_valid_q;

  // No register on R, narrow beat is valid with the wide one
  assign slv_r_valid_o = active && mst_r_valid_i;
  assign r_hs          = slv_r_valid_o && slv_r_ready_i;

  assign addr_next = next_addr(addr_q, size_q, burst_q);
  assign word_used = (state_q == R_PASSTHROUGH) || (cnt_q == 9'd1) ||
                     (aligned_addr(addr_next, MST_MAX_SIZE) != aligned_addr(addr_q, MST_MAX_SIZE));

  // Release the wide beat once its last narrow part is taken
  assign mst_r_ready_o = r_hs && word_used;

  always_comb begin
    ar_rewritten = slv_ar_i;
    if (is_upsizable(slv_ar_i)) begin
      ar_rewritten.len  = upsized_len(slv_ar_i.addr, slv_ar_i.size, slv_ar_i.len);
      ar_rewritten.size = MST_MAX_SIZE;
    end
  end

  // Steer the active half of the wide word onto the narrow lanes
  always_comb begin
    int unsigned lane;
    slv_r_o = '0;
    for (int n = 0; n < SLV_STRB_W; n++) begin
      lane = addr_q[2] ? n + SLV_STRB_W : n;
      if (lane_in_beat(3'(lane), addr_q, size_q)) begin
        slv_r_o.data[8*n +: 8] = mst_r_i.data[8*lane +: 8];
      end
    end
    slv_r_o.resp = mst_r_i.resp;
    slv_r_o.last = (cnt_q == 9'd1);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= R_IDLE;
      ar_valid_q <= 1'b0;
      cnt_q      <= '0;
    end else if (ar_hs) begin
      state_q    <= is_upsizable(slv_ar_i) ? R_UPSIZE : R_PASSTHROUGH;
      ar_valid_q <= 1'b1;
      cnt_q      <= {1'b0, slv_ar_i.len} + 9'd1;
    end else begin
      if (ar_valid_q && mst_ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
      if (r_hs) begin
        cnt_q <= cnt_q - 9'd1;
        if (cnt_q == 9'd1) begin
          state_q <= R_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      ar_q    <= ar_rewritten;
      addr_q  <= slv_ar_i.addr;
      size_q  <= slv_ar_i.size;
      burst_q <= slv_ar_i.burst;
    end else if (r_hs) begin
      addr_q <= addr_next;
    end
  end

  assign mst_ar_o       = ar_q;
  assign mst_ar_valid_o = ar_valid_q;

  // The final narrow beat has to come out of the wide slave's final beat
  a_last_in_last_wide : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (slv_r_valid_o && slv_r_o.last) |-> mst_r_i.last
  );

endmodule

// File: logic/dwc_write_packer.sv
// Write path of the upsizer. Registers one AW request, rewrites it for the
// wide bus and packs the narrow W beats into wide beats with strobes.
`timescale 1ns/100ps

module dwc_write_packer
  import dwc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  dwc_ax_t    slv_aw_i,
  input  logic       slv_aw_valid_i,
  output logic       slv_aw_ready_o,
  input  dwc_slv_w_t slv_w_i,
  input  logic       slv_w_valid_i,
  output logic       slv_w_ready_o,
  output dwc_ax_t    mst_aw_o,
  output logic       mst_aw_valid_o,
  input  logic       mst_aw_ready_i,
  output dwc_mst_w_t mst_w_o,
  output logic       mst_w_valid_o,
  input  logic       mst_w_ready_i
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_PASSTHROUGH,
    W_UPSIZE
  } w_state_e;

  w_state_e          state_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  // Narrow beats still to be accepted
  logic [8:0]        cnt_q;

  dwc_ax_t           aw_q;
  logic [ADDR_W-1:0] addr_q;
  logic [2:0]        size_q;
  logic [1:0]        burst_q;
  dwc_mst_w_t        w_q;

  logic              aw_hs;
  logic              w_hs;
  logic              mst_w_hs;
  logic [ADDR_W-1:0] addr_next;
  logic              word_full;
  dwc_ax_t           aw_rewritten;
  dwc_mst_w_t        w_packed;

  assign slv_aw_ready_o = (state_q == W_IDLE);
  assign aw_hs          = slv_aw_valid_i && slv_aw_ready_o;
  assign mst_w_hs       = w_valid_q && mst_w_ready_i;

  // Data flows only after the wide AW is gone and the wide register has room
  assign slv_w_ready_o = (state_q != W_IDLE) && !aw_valid_q && (cnt_q != 9'd0) &&
                         (!w_valid_q || mst_w_ready_i);
  assign w_hs          = slv_w_valid_i && slv_w_ready_o;

  assign addr_next = next_addr(addr_q, size_q, burst_q);
  assign word_full = (state_q == W_PASSTHROUGH) || (cnt_q == 9'd1) ||
                     (aligned_addr(addr_next, MST_MAX_SIZE) != aligned_addr(addr_q, MST_MAX_SIZE));

  always_comb begin
    aw_rewritten = slv_aw_i;
    if (is_upsizable(slv_aw_i)) begin
      aw_rewritten.len  = upsized_len(slv_aw_i.addr, slv_aw_i.size, slv_aw_i.len);
      aw_rewritten.size = MST_MAX_SIZE;
    end
  end

  // Merge the narrow beat into the wide word, fresh word if the old one drains
  always_comb begin
    w_packed = w_valid_q ? '0 : w_q;
    for (int b = 0; b < MST_STRB_W; b++) begin
      if (lane_in_beat(3'(b), addr_q, size_q)) begin
        w_packed.data[8*b +: 8] = slv_w_i.data[8*(b % SLV_STRB_W) +: 8];
        w_packed.strb[b]        = slv_w_i.strb[b % SLV_STRB_W];
      end
    end
    w_packed.last = (cnt_q == 9'd1);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= W_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      cnt_q      <= '0;
    end else if (aw_hs) begin
      state_q    <= is_upsizable(slv_aw_i) ? W_UPSIZE : W_PASSTHROUGH;
      aw_valid_q <= 1'b1;
      cnt_q      <= {1'b0, slv_aw_i.len} + 9'd1;
    end else begin
      if (aw_valid_q && mst_aw_ready_i) begin
        aw_valid_q <= 1'b0;
      end
      if (w_hs) begin
        cnt_q     <= cnt_q - 9'd1;
        w_valid_q <= word_full;
      end else if (mst_w_hs) begin
        w_valid_q <= 1'b0;
      end
      // Final wide beat leaves, idle from the next cycle
      if (mst_w_hs && w_q.last) begin
        state_q <= W_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q    <= aw_rewritten;
      addr_q  <= slv_aw_i.addr;
      size_q  <= slv_aw_i.size;
      burst_q <= slv_aw_i.burst;
      w_q     <= '0;
    end else if (w_hs) begin
      addr_q <= addr_next;
      w_q    <= w_packed;
    end else if (mst_w_hs) begin
      w_q <= '0;
    end
  end

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_o        = w_q;
  assign mst_w_valid_o  = w_valid_q;

  // Last wide beat only once every narrow beat has been taken
  a_last_after_all_beats : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mst_w_valid_o && mst_w_o.last) |-> (cnt_q == 9'd0)
  );

endmodule

// File: logic/dwc_pkg.sv
// Shared widths, channel payload types and burst helpers for the 32-to-64 bit
// AXI upsizer. The write path, the read path, the top level and the testbench
// all import this package.
package dwc_pkg;

  localparam int unsigned SLV_DATA_W = 32;
  localparam int unsigned MST_DATA_W = 64;
  localparam int unsigned SLV_STRB_W = SLV_DATA_W / 8;
  localparam int unsigned MST_STRB_W = MST_DATA_W / 8;
  localparam int unsigned ADDR_W     = 32;

  // Size code of one full wide beat (8 bytes)
  localparam logic [2:0] MST_MAX_SIZE = 3'd3;

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  localparam int unsigned CACHE_MODIFIABLE_BIT = 1;

  // AW and AR request, same layout on both sides
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [3:0]        cache;
  } dwc_ax_t;

  typedef struct packed {
    logic [SLV_DATA_W-1:0] data;
    logic [SLV_STRB_W-1:0] strb;
    logic                  last;
  } dwc_slv_w_t;

  typedef struct packed {
    logic [MST_DATA_W-1:0] data;
    logic [MST_STRB_W-1:0] strb;
    logic                  last;
  } dwc_mst_w_t;

  typedef struct packed {
    logic [SLV_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } dwc_slv_r_t;

  typedef struct packed {
    logic [MST_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } dwc_mst_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } dwc_b_t;

  function automatic logic [ADDR_W-1:0] aligned_addr(input logic [ADDR_W-1:0] addr,
                                                     input logic [2:0]        size);
    return (addr >> size) << size;
  endfunction

  // Wide burst length covering every byte of the narrow burst
  function automatic logic [7:0] upsized_len(input logic [ADDR_W-1:0] addr,
                                             input logic [2:0]        size,
                                             input logic [7:0]        len);
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
    logic [ADDR_W-1:0] span;
    start_addr = aligned_addr(addr, MST_MAX_SIZE);
    end_addr   = aligned_addr(aligned_addr(addr, size) + (ADDR_W'(len) << size), MST_MAX_SIZE);
    span       = (end_addr - start_addr) >> MST_MAX_SIZE;
    return span[7:0];
  endfunction

  function automatic logic is_upsizable(input dwc_ax_t ax);
    return (ax.burst == BURST_INCR) && ax.cache[CACHE_MODIFIABLE_BIT] && (ax.len != 8'd0);
  endfunction

  // Address of the following narrow beat; WRAP steps like INCR here
  function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] addr,
                                                  input logic [2:0]        size,
                                                  input logic [1:0]        burst);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return aligned_addr(addr, size) + (ADDR_W'(1) << size);
  endfunction

  // True when wide byte lane belongs to the beat at addr of the given size
  function automatic logic lane_in_beat(input logic [2:0]        lane,
                                        input logic [ADDR_W-1:0] addr,
                                        input logic [2:0]        size);
    return (lane >> size) == (addr[2:0] >> size);
  endfunction

endpackage
